// File: hdl/cdc_fifo_pkg.sv
`default_nettype none

package cdc_fifo_pkg;

  // number of memory address bits
  localparam int addr_size = 4;

  // the FIFO holds a power-of-two number of words
  localparam int fifo_depth = 1 << addr_size;

  // almost-full rises once the free space shrinks to this many words
  localparam int almost_full_buf = 2;

  // payload field widths
  localparam int tag_width  = 4;
  localparam int data_width = 16;

  // one extra bit above the address tells one wrap pass from the next
  typedef logic [addr_size:0] ptr_t;

  // address into the storage array
  typedef logic [addr_size-1:0] addr_t;

  // the word carried across the clock domains
  typedef struct packed {
    logic [tag_width-1:0]  tag;
    logic [data_width-1:0] data;
  } fifo_word_t;

  // undo the Gray code by a running xor from the top bit down
  function automatic ptr_t gray_to_bin(input ptr_t gray);
    ptr_t bin;
    bin[addr_size] = gray[addr_size];
    // each binary bit is the xor of every Gray bit at or above it
    for (int i = addr_size - 1; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

`default_nettype wire

// File: hdl/cdc_fifo_sync2.sv
`timescale 1ns/1ps
`default_nettype none

module cdc_fifo_sync2 (
  input  logic                clk,
  input  logic                rst_n,
  input  cdc_fifo_pkg::ptr_t  d,
  output cdc_fifo_pkg::ptr_t  q
);
  import cdc_fifo_pkg::*;

  // first stage may go metastable and is only ever read by the second
  ptr_t meta;

  // the incoming pointer is Gray coded, so at most one bit moves per
  // source edge and a late sample lands on either the old or the new value
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      meta <= '0;
      q    <= '0;
    end else begin
      meta <= d;
      q    <= meta;
    end
  end

endmodule

`default_nettype wire

// File: hdl/cdc_fifo_mem.sv
`timescale 1ns/1ps
`default_nettype none

module cdc_fifo_mem (
  input  logic                       w_clk,
  input  logic                       w_en,
  input  cdc_fifo_pkg::addr_t        w_addr,
  input  cdc_fifo_pkg::fifo_word_t   w_data,
  input  cdc_fifo_pkg::addr_t        r_addr,
  output cdc_fifo_pkg::fifo_word_t   r_data
);
  import cdc_fifo_pkg::*;

  // one entry per FIFO slot, holding payload only
  fifo_word_t mem [fifo_depth];

  // written in the write domain on an accepted write
  always_ff @(posedge w_clk) begin
    if (w_en) begin
      mem[w_addr] <= w_data;
    end
  end

  // the read side sees the head word without waiting for a clock edge
  assign r_data = mem[r_addr];

endmodule

`default_nettype wire

// File: hdl/cdc_fifo_wptr_full.sv
`timescale 1ns/1ps
`default_nettype none

module cdc_fifo_wptr_full (
  input  logic                 w_clk,
  input  logic                 w_rst_n,
  input  logic                 w_inc,
  input  cdc_fifo_pkg::ptr_t   w_q2_rptr,
  output logic                 w_full,
  output logic                 w_almost_full,
  output cdc_fifo_pkg::ptr_t   w_ptr,
  output cdc_fifo_pkg::addr_t  w_addr,
  output logic                 w_en
);
  import cdc_fifo_pkg::*;

  ptr_t w_bin;
  ptr_t w_bin_next;
  ptr_t w_gray_next;
  ptr_t w_r_bin;
  ptr_t w_slots_used;
  logic w_full_val;
  logic w_almost_full_val;

  // a write is taken only while there is room, so a write into a full FIFO is dropped
  assign w_en = w_inc && !w_full;

  // the memory is addressed with the low binary bits
  assign w_addr = w_bin[addr_size-1:0];

  // next binary pointer and its Gray copy
  assign w_bin_next  = w_bin + ptr_t'(w_en);
  assign w_gray_next = (w_bin_next >> 1) ^ w_bin_next;

  always_ff @(posedge w_clk) begin
    if (!w_rst_n) begin
      w_bin <= '0;
      w_ptr <= '0;
    end else begin
      w_bin <= w_bin_next;
      w_ptr <= w_gray_next;
    end
  end

  // full when the write side is exactly one lap ahead of the read side
  // which in Gray code shows up as the top two bits inverted
  assign w_full_val = (w_gray_next == {~w_q2_rptr[addr_size:addr_size-1],
                                       w_q2_rptr[addr_size-2:0]});

  // Gray codes cannot be subtracted, so the read pointer goes back to binary
  assign w_r_bin = gray_to_bin(w_q2_rptr);

  // words in use as seen from the write side, counted after this edge
  assign w_slots_used = w_bin_next - w_r_bin;

  assign w_almost_full_val = (w_slots_used >= ptr_t'(fifo_depth - almost_full_buf));

  // both flags come from the next pointer, so they rise right after the write edge
  always_ff @(posedge w_clk) begin
    if (!w_rst_n) begin
      w_full        <= 1'b0;
      w_almost_full <= 1'b0;
    end else begin
      w_full        <= w_full_val;
      w_almost_full <= w_almost_full_val;
    end
  end

  // the write pointer never runs more than one full array ahead of the read
  // pointer it sees, otherwise unread words would be overwritten
  a_no_overrun: assert property (
    @(posedge w_clk) disable iff (!w_rst_n)
      ptr_t'(w_bin - w_r_bin) <= ptr_t'(fifo_depth)
  );

  // almost-full threshold sits below full, so full always implies almost-full
  a_full_implies_almost: assert property (
    @(posedge w_clk) disable iff (!w_rst_n) w_full |-> w_almost_full
  );

endmodule

`default_nettype wire

// File: hdl/cdc_fifo_rptr_empty.sv
`timescale 1ns/1ps
`default_nettype none

module cdc_fifo_rptr_empty (
  input  logic                 r_clk,
  input  logic                 r_rst_n,
  input  logic                 r_inc,
  input  cdc_fifo_pkg::ptr_t   r_q2_wptr,
  output logic                 r_empty,
  output cdc_fifo_pkg::ptr_t   r_ptr,
  output cdc_fifo_pkg::addr_t  r_addr
);
  import cdc_fifo_pkg::*;

  ptr_t r_bin;
  ptr_t r_bin_next;
  ptr_t r_gray_next;
  logic r_en;
  logic r_empty_val;

  // a pop only counts while a word is there to be popped
  assign r_en = r_inc && !r_empty;

  // head word address for the combinational memory read
  assign r_addr = r_bin[addr_size-1:0];

  assign r_bin_next  = r_bin + ptr_t'(r_en);
  assign r_gray_next = (r_bin_next >> 1) ^ r_bin_next;

  always_ff @(posedge r_clk) begin
    if (!r_rst_n) begin
      r_bin <= '0;
      r_ptr <= '0;
    end else begin
      r_bin <= r_bin_next;
      r_ptr <= r_gray_next;
    end
  end

  // empty when the read side has caught up with the synchronized write pointer
  // and both Gray pointers then match bit for bit
  assign r_empty_val = (r_gray_next == r_q2_wptr);

  // registered from the next pointer, so it rises right after the last pop
  always_ff @(posedge r_clk) begin
    if (!r_rst_n) begin
      r_empty <= 1'b1;
    end else begin
      r_empty <= r_empty_val;
    end
  end

  // a head word is offered only while the read pointer still trails the
  // synchronized write pointer, which only ever moves forward
  a_word_behind_not_empty: assert property (
    @(posedge r_clk) disable iff (!r_rst_n) !r_empty |-> (r_ptr != r_q2_wptr)
  );

  // the write side may run ahead by at most one full array, never more
  a_fill_in_range: assert property (
    @(posedge r_clk) disable iff (!r_rst_n)
      ptr_t'(gray_to_bin(r_q2_wptr) - r_bin) <= ptr_t'(fifo_depth)
  );

endmodule

`default_nettype wire

// File: hdl/cdc_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module cdc_fifo (
  input  logic                       w_clk,
  input  logic                       w_rst_n,
  input  logic                       w_inc,
  input  cdc_fifo_pkg::fifo_word_t   w_data,
  output logic                       w_full,
  output logic                       w_almost_full,
  input  logic                       r_clk,
  input  logic                       r_rst_n,
  input  logic                       r_inc,
  output cdc_fifo_pkg::fifo_word_t   r_data,
  output logic                       r_empty
);
  import cdc_fifo_pkg::*;

  // Gray pointers in their home domain
  ptr_t w_ptr;
  ptr_t r_ptr;

  // the same pointers after crossing into the other domain
  ptr_t w_q2_rptr;
  ptr_t r_q2_wptr;

  addr_t w_addr;
  addr_t r_addr;
  logic  w_en;

  cdc_fifo_mem u_mem (
    .w_clk  (w_clk),
    .w_en   (w_en),
    .w_addr (w_addr),
    .w_data (w_data),
    .r_addr (r_addr),
    .r_data (r_data)
  );

  cdc_fifo_wptr_full u_wptr_full (
    .w_clk         (w_clk),
    .w_rst_n       (w_rst_n),
    .w_inc         (w_inc),
    .w_q2_rptr     (w_q2_rptr),
    .w_full        (w_full),
    .w_almost_full (w_almost_full),
    .w_ptr         (w_ptr),
    .w_addr        (w_addr),
    .w_en          (w_en)
  );

  cdc_fifo_rptr_empty u_rptr_empty (
    .r_clk     (r_clk),
    .r_rst_n   (r_rst_n),
    .r_inc     (r_inc),
    .r_q2_wptr (r_q2_wptr),
    .r_empty   (r_empty),
    .r_ptr     (r_ptr),
    .r_addr    (r_addr)
  );

  // write pointer into the read domain
  cdc_fifo_sync2 u_sync_w2r (
    .clk   (r_clk),
    .rst_n (r_rst_n),
    .d     (w_ptr),
    .q     (r_q2_wptr)
  );

  // read pointer into the write domain
  cdc_fifo_sync2 u_sync_r2w (
    .clk   (w_clk),
    .rst_n (w_rst_n),
    .d     (r_ptr),
    .q     (w_q2_rptr)
  );

endmodule

`default_nettype wire

// File: sim/cdc_fifo_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cdc_fifo_tb;
  import cdc_fifo_pkg::*;

  // one row of the phase table with its expected settled flag levels
  typedef struct packed {
    logic [15:0] n_writes;
    logic [15:0] n_reads;
    logic        concurrent;
    logic        check_flags;
    logic        exp_full;
    logic        exp_almost_full;
    logic        exp_empty;
  } phase_t;

  localparam int num_phases = 7;
  localparam int settle_cycles = 10;

  logic       w_clk, w_rst_n, w_inc, w_full, w_almost_full;
  logic       r_clk, r_rst_n, r_inc, r_empty;
  fifo_word_t w_data, r_data;

  phase_t     phases [num_phases];
  fifo_word_t ref_q [$];
  integer     seed = 43;
  int         word_count = 0;
  int         data_errors = 0;
  int         flag_errors = 0;
  int         other_errors = 0;

  cdc_fifo i_dut (
    .w_clk(w_clk), .w_rst_n(w_rst_n), .w_inc(w_inc), .w_data(w_data),
    .w_full(w_full), .w_almost_full(w_almost_full),
    .r_clk(r_clk), .r_rst_n(r_rst_n), .r_inc(r_inc), .r_data(r_data),
    .r_empty(r_empty)
  );

  initial begin
    w_clk = 1'b0;
    forever #20 w_clk = ~w_clk;
  end

  // read clock runs at the same rate but 17 ns late, so edges never coincide
  initial begin
    r_clk = 1'b0;
    #17;
    forever #20 r_clk = ~r_clk;
  end

  // a word counts as written only if w_full was low at the edge that took w_inc
  task automatic drive_writes(input int attempts, input bit random_inc);
    int         done;
    logic [31:0] rnd;
    fifo_word_t word;
    done = 0;
    while (done < attempts) begin
      @(posedge w_clk);
      if (w_inc) begin
        // dropped words never enter the model, so they must never come out
        if (!w_full) ref_q.push_back(w_data);
        done++;
      end
      if (done < attempts) begin
        rnd = $random(seed);
        word.tag  = word_count[3:0];
        word.data = {word_count[7:0], rnd[23:16]};
        word_count++;
        w_inc  <= random_inc ? rnd[0] : 1'b1;
        w_data <= word;
      end else begin
        w_inc <= 1'b0;
      end
    end
  endtask

  // compare the head word seen at this edge against the oldest model entry
  task automatic check_pop();
    fifo_word_t expected;
    assert (ref_q.size() > 0) else begin
      other_errors++;
      $display("a read at %0t ns returned a word while the model was empty", $time);
    end
    if (ref_q.size() > 0) begin
      expected = ref_q.pop_front();
      assert (r_data === expected) else begin
        data_errors++;
        $display("ERROR %0t ns: r_data expected %h got %h", $time, expected, r_data);
      end
    end
  endtask

  task automatic drive_reads(input int attempts, input bit random_inc);
    int          done;
    logic [31:0] rnd;
    done = 0;
    while (done < attempts) begin
      @(posedge r_clk);
      if (r_inc) begin
        if (!r_empty) check_pop();
        done++;
      end
      if (done < attempts) begin
        rnd = $random(seed);
        r_inc <= random_inc ? rnd[0] : 1'b1;
      end else begin
        r_inc <= 1'b0;
      end
    end
  endtask

  task automatic check_flag(input string name, input logic actual, input logic expected);
    assert (actual === expected) else begin
      flag_errors++;
      $display("ERROR %0t ns: %s expected %b got %b", $time, name, expected, actual);
    end
  endtask

  // watchdog budget is the summed attempts plus settle time, doubled
  function automatic int watchdog_ns();
    int cycles;
    cycles = 0;
    for (int p = 0; p < num_phases; p++) begin
      cycles += int'(phases[p].n_writes) + int'(phases[p].n_reads) + settle_cycles;
    end
    return cycles * 40 * 2;
  endfunction

  initial begin
    phase_t row;
    int     limit_ns;
    w_rst_n = 1'b0;
    r_rst_n = 1'b0;
    w_inc   = 1'b0;
    r_inc   = 1'b0;
    w_data  = '0;
    // writes, reads, concurrent, check, full, almost-full, empty
    phases[0] = '{16'd0,   16'd0,   1'b0, 1'b1, 1'b0, 1'b0, 1'b1};
    phases[1] = '{16'd13,  16'd0,   1'b0, 1'b1, 1'b0, 1'b0, 1'b0};
    phases[2] = '{16'd1,   16'd0,   1'b0, 1'b1, 1'b0, 1'b1, 1'b0};
    phases[3] = '{16'd4,   16'd0,   1'b0, 1'b1, 1'b1, 1'b1, 1'b0};
    phases[4] = '{16'd0,   16'd20,  1'b0, 1'b1, 1'b0, 1'b0, 1'b1};
    phases[5] = '{16'd200, 16'd200, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};
    phases[6] = '{16'd0,   16'd40,  1'b0, 1'b1, 1'b0, 1'b0, 1'b1};
    limit_ns = watchdog_ns();
    fork
      begin
        #(limit_ns);
        $display("watchdog expired after %0d ns before the phase table finished", limit_ns);
        $display("Testbench failed");
        $finish;
      end
      begin
        // each reset is released on its own clock after 5 cycles
        fork
          begin
            repeat (5) @(posedge w_clk);
            w_rst_n <= 1'b1;
          end
          begin
            repeat (5) @(posedge r_clk);
            r_rst_n <= 1'b1;
          end
        join
        for (int p = 0; p < num_phases; p++) begin
          row = phases[p];
          if (row.concurrent) begin
            fork
              drive_writes(int'(row.n_writes), 1'b1);
              drive_reads(int'(row.n_reads), 1'b1);
            join
          end else begin
            drive_writes(int'(row.n_writes), 1'b0);
            drive_reads(int'(row.n_reads), 1'b0);
          end
          // pointers need about three cycles to cross, ten leaves the flags settled
          repeat (settle_cycles) @(posedge w_clk);
          @(negedge w_clk);
          if (row.check_flags) begin
            check_flag("w_full", w_full, row.exp_full);
            check_flag("w_almost_full", w_almost_full, row.exp_almost_full);
            check_flag("r_empty", r_empty, row.exp_empty);
          end
        end
        assert (ref_q.size() == 0) else begin
          other_errors++;
          $display("the model still holds %0d words after the final drain", ref_q.size());
        end
        $display("errors: %0d data, %0d flag, %0d other", data_errors, flag_errors,
                 other_errors);
        if (data_errors + flag_errors + other_errors == 0) begin
          $display("Testbench passed");
        end else begin
          $display("Testbench failed");
        end
        $finish;
      end
    join_any
  end

endmodule

`default_nettype wire

// File: flist.f
hdl/cdc_fifo_pkg.sv
hdl/cdc_fifo_sync2.sv
hdl/cdc_fifo_mem.sv
hdl/cdc_fifo_wptr_full.sv
hdl/cdc_fifo_rptr_empty.sv
hdl/cdc_fifo.sv
sim/cdc_fifo_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := cdc_fifo_tb
RTL_TOP    := cdc_fifo
FLIST      := flist.f
SIM_FLAGS  := --binary --timing --assert --timescale 1ns/1ps
LINT_FLAGS := --lint-only -Wall --timing --timescale 1ns/1ps
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Testbench failed" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
